//--- verilog/mc_wh_pkg.sv
`default_nettype none

package mc_wh_pkg;

  // Link geometry
  localparam int num_nets        = 2;
  localparam int wh_flit_width   = 32;
  localparam int wh_ratio        = 3;
  localparam int wh_packet_bits  = wh_flit_width * wh_ratio;
  localparam int wh_coord_width  = 4;
  localparam int mc_packet_width = 64;

  // Net indices, same numbering as the manycore link
  localparam int rev_net = 0;
  localparam int fwd_net = 1;

  // Reserved value of op and pkt_type
  localparam logic [1:0] mc_reserved_code = 2'd3;

  // Request packet on the forward net
  typedef struct packed {
    logic [1:0]  op;
    logic [23:0] addr;
    logic [31:0] data;
    logic [2:0]  src_y;
    logic [2:0]  src_x;
  } mc_fwd_packet_t;

  // Return packet on the reverse net
  typedef struct packed {
    logic [18:0] pad;
    logic [1:0]  pkt_type;
    logic [4:0]  load_id;
    logic [31:0] data;
    logic [2:0]  src_y;
    logic [2:0]  src_x;
  } mc_rev_packet_t;

  // Same 64 bits, read by net direction
  typedef union packed {
    mc_fwd_packet_t fwd;
    mc_rev_packet_t rev;
  } mc_payload_u;

  typedef struct packed {
    logic [1:0]                reserved;
    logic [wh_coord_width-1:0] x;
    logic [wh_coord_width-1:0] y;
    logic [1:0]                len;
  } wh_header_t;

  // Header in the low bits so it leaves in the first flit
  typedef struct packed {
    mc_payload_u payload;
    wh_header_t  hdr;
  } wh_packet_t;

endpackage

`default_nettype wire

//--- verilog/mc_link_framer.sv
`default_nettype none
`timescale 1ns/1ns

module mc_link_framer (
  input  wire                                                   manycore_clk_i,
  input  wire                                                   arst_n_i,
  input  wire  [mc_wh_pkg::num_nets-1:0]                        mc_v_i,
  input  wire  [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::mc_packet_width-1:0] mc_data_i,
  output logic [mc_wh_pkg::num_nets-1:0]                        mc_ready_o,
  input  wire  [mc_wh_pkg::wh_coord_width-1:0]                  dest_x_i,
  input  wire  [mc_wh_pkg::wh_coord_width-1:0]                  dest_y_i,
  output logic [mc_wh_pkg::num_nets-1:0]                        pkt_v_o,
  output logic [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::wh_packet_bits-1:0] pkt_data_o,
  input  wire  [mc_wh_pkg::num_nets-1:0]                        pkt_ready_i
);

  localparam int pad_bits_lp = mc_wh_pkg::wh_packet_bits - $bits(mc_wh_pkg::wh_packet_t);

  mc_wh_pkg::mc_payload_u [mc_wh_pkg::num_nets-1:0] slot_data;
  mc_wh_pkg::wh_packet_t  [mc_wh_pkg::num_nets-1:0] tx_pkt;
  logic                   [mc_wh_pkg::num_nets-1:0] accept;

  // Slot refills when empty or when it drains on this edge
  assign mc_ready_o = ~pkt_v_o | pkt_ready_i;
  assign accept     = mc_v_i & mc_ready_o;

  always_ff @(posedge manycore_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      pkt_v_o <= '0;
    else
      pkt_v_o <= accept | (pkt_v_o & ~pkt_ready_i);
  end

  always_ff @(posedge manycore_clk_i)
  begin
    for (int i = 0; i < mc_wh_pkg::num_nets; i++)
    begin
      if (accept[i])
        slot_data[i] <= mc_data_i[i];
    end
  end

  // Wrap the held payload in a wormhole header
  always_comb
  begin
    for (int i = 0; i < mc_wh_pkg::num_nets; i++)
    begin
      tx_pkt[i].hdr.reserved = '0;
      tx_pkt[i].hdr.x        = dest_x_i;
      tx_pkt[i].hdr.y        = dest_y_i;
      tx_pkt[i].hdr.len      = 2'(mc_wh_pkg::wh_ratio - 1);
      tx_pkt[i].payload      = slot_data[i];
      pkt_data_o[i]          = {{pad_bits_lp{1'b0}}, tx_pkt[i]};
    end
  end

endmodule

`default_nettype wire

//--- verilog/wh_piso.sv
`default_nettype none
`timescale 1ns/1ns

module wh_piso (
  input  wire                                   clk_i,
  input  wire                                   arst_n_i,
  input  wire                                   v_i,
  input  wire  [mc_wh_pkg::wh_packet_bits-1:0]  data_i,
  output logic                                  ready_o,
  output logic                                  v_o,
  output logic [mc_wh_pkg::wh_flit_width-1:0]   data_o,
  input  wire                                   ready_i
);

  localparam int cnt_width_lp = $clog2(mc_wh_pkg::wh_ratio);
  localparam logic [cnt_width_lp-1:0] last_flit_lp = cnt_width_lp'(mc_wh_pkg::wh_ratio - 1);

  logic [mc_wh_pkg::wh_packet_bits-1:0] shift_q;
  logic [cnt_width_lp-1:0]              flit_cnt;
  logic                                 busy;

  assign ready_o = ~busy;
  assign v_o     = busy;
  assign data_o  = shift_q[mc_wh_pkg::wh_flit_width-1:0];

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      busy     <= 1'b0;
      flit_cnt <= '0;
    end
    else if (v_i && ready_o)
    begin
      busy     <= 1'b1;
      flit_cnt <= '0;
    end
    else if (busy && ready_i)
    begin
      // Free again once the last flit is taken
      busy     <= (flit_cnt != last_flit_lp);
      flit_cnt <= flit_cnt + 1'b1;
    end
  end

  // Low flit goes first
  always_ff @(posedge clk_i)
  begin
    if (v_i && ready_o)
      shift_q <= data_i;
    else if (busy && ready_i)
      shift_q <= shift_q >> mc_wh_pkg::wh_flit_width;
  end

endmodule

`default_nettype wire

//--- verilog/wh_sipo.sv
`default_nettype none
`timescale 1ns/1ns

module wh_sipo (
  input  wire                                   clk_i,
  input  wire                                   arst_n_i,
  input  wire                                   v_i,
  input  wire  [mc_wh_pkg::wh_flit_width-1:0]   data_i,
  output logic                                  ready_o,
  output logic                                  v_o,
  output logic [mc_wh_pkg::wh_packet_bits-1:0]  data_o,
  input  wire                                   ready_i
);

  localparam int cnt_width_lp = $clog2(mc_wh_pkg::wh_ratio);
  localparam logic [cnt_width_lp-1:0] last_flit_lp = cnt_width_lp'(mc_wh_pkg::wh_ratio - 1);

  logic [mc_wh_pkg::wh_ratio-1:0][mc_wh_pkg::wh_flit_width-1:0] flits_q;
  logic [cnt_width_lp-1:0]                                      flit_cnt;
  logic                                                         full;

  // No flits taken while a whole packet waits
  assign ready_o = ~full;
  assign v_o     = full;
  assign data_o  = flits_q;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      full     <= 1'b0;
      flit_cnt <= '0;
    end
    else if (v_i && ready_o)
    begin
      full     <= (flit_cnt == last_flit_lp);
      flit_cnt <= (flit_cnt == last_flit_lp) ? '0 : flit_cnt + 1'b1;
    end
    else if (full && ready_i)
      full <= 1'b0;
  end

  // First flit lands in the low slot
  always_ff @(posedge clk_i)
  begin
    if (v_i && ready_o)
      flits_q[flit_cnt] <= data_i;
  end

endmodule

`default_nettype wire

//--- verilog/wh_async_fifo.sv
`default_nettype none
`timescale 1ns/1ns

module wh_async_fifo #(
  parameter int lg_fifo_depth_p = 3
) (
  input  wire                                  w_clk_i,
  input  wire                                  r_clk_i,
  input  wire                                  arst_n_i,
  input  wire                                  w_v_i,
  input  wire  [mc_wh_pkg::wh_flit_width-1:0]  w_data_i,
  output logic                                 w_ready_o,
  output logic                                 r_v_o,
  output logic [mc_wh_pkg::wh_flit_width-1:0]  r_data_o,
  input  wire                                  r_ready_i
);

  localparam int depth_lp = 1 << lg_fifo_depth_p;
  // Gray pattern of a pointer exactly one lap ahead
  localparam logic [lg_fifo_depth_p:0] lap_mask_lp = (lg_fifo_depth_p + 1)'(3 << (lg_fifo_depth_p - 1));

  logic [mc_wh_pkg::wh_flit_width-1:0] mem [depth_lp];

  logic [lg_fifo_depth_p:0] w_bin, w_gray, w_bin_next;
  logic [lg_fifo_depth_p:0] r_bin, r_gray, r_bin_next;
  // Other side's gray pointer after two flops
  logic [lg_fifo_depth_p:0] w_rgray_s1, w_rgray_s2;
  logic [lg_fifo_depth_p:0] r_wgray_s1, r_wgray_s2;

  assign w_bin_next = w_bin + 1'b1;
  assign r_bin_next = r_bin + 1'b1;

  // Write side, strobes arrive already gated with w_ready_o
  always_ff @(posedge w_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      w_bin      <= '0;
      w_gray     <= '0;
      w_rgray_s1 <= '0;
      w_rgray_s2 <= '0;
    end
    else
    begin
      w_rgray_s1 <= r_gray;
      w_rgray_s2 <= w_rgray_s1;
      if (w_v_i)
      begin
        w_bin  <= w_bin_next;
        w_gray <= w_bin_next ^ (w_bin_next >> 1);
      end
    end
  end

  always_ff @(posedge w_clk_i)
  begin
    if (w_v_i)
      mem[w_bin[lg_fifo_depth_p-1:0]] <= w_data_i;
  end

  assign w_ready_o = (w_gray != (w_rgray_s2 ^ lap_mask_lp));

  // Read side, r_ready_i only counts while r_v_o is high
  always_ff @(posedge r_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      r_bin      <= '0;
      r_gray     <= '0;
      r_wgray_s1 <= '0;
      r_wgray_s2 <= '0;
    end
    else
    begin
      r_wgray_s1 <= w_gray;
      r_wgray_s2 <= r_wgray_s1;
      if (r_ready_i)
      begin
        r_bin  <= r_bin_next;
        r_gray <= r_bin_next ^ (r_bin_next >> 1);
      end
    end
  end

  assign r_v_o    = (r_gray != r_wgray_s2);
  assign r_data_o = mem[r_bin[lg_fifo_depth_p-1:0]];

endmodule

`default_nettype wire

//--- verilog/wh_net_lane.sv
`default_nettype none
`timescale 1ns/1ns

module wh_net_lane #(
  parameter int lg_fifo_depth_p = 3
) (
  input  wire                                   manycore_clk_i,
  input  wire                                   clk_i,
  input  wire                                   arst_n_i,
  input  wire                                   tx_v_i,
  input  wire  [mc_wh_pkg::wh_packet_bits-1:0]  tx_data_i,
  output logic                                  tx_ready_o,
  output logic                                  rx_v_o,
  output logic [mc_wh_pkg::wh_packet_bits-1:0]  rx_data_o,
  input  wire                                   rx_ready_i,
  output logic                                  wh_v_o,
  output logic [mc_wh_pkg::wh_flit_width-1:0]   wh_data_o,
  input  wire                                   wh_ready_i,
  input  wire                                   wh_v_i,
  input  wire  [mc_wh_pkg::wh_flit_width-1:0]   wh_data_i,
  output logic                                  wh_ready_o
);

  logic                                piso_v, out_w_ready, out_enq, out_deq;
  logic [mc_wh_pkg::wh_flit_width-1:0] piso_data;
  logic                                in_r_v, in_enq, in_deq, sipo_ready;
  logic [mc_wh_pkg::wh_flit_width-1:0] in_r_data;

  // FIFO strobes only on real transfers
  assign out_enq = piso_v & out_w_ready;
  assign out_deq = wh_v_o & wh_ready_i;
  assign in_enq  = wh_v_i & wh_ready_o;
  assign in_deq  = in_r_v & sipo_ready;

  wh_piso piso_inst (
    .clk_i(manycore_clk_i), .arst_n_i(arst_n_i),
    .v_i(tx_v_i), .data_i(tx_data_i), .ready_o(tx_ready_o),
    .v_o(piso_v), .data_o(piso_data), .ready_i(out_w_ready)
  );

  // Manycore clock to wormhole clock
  wh_async_fifo #(.lg_fifo_depth_p(lg_fifo_depth_p)) mc_to_wh_inst (
    .w_clk_i(manycore_clk_i), .r_clk_i(clk_i), .arst_n_i(arst_n_i),
    .w_v_i(out_enq), .w_data_i(piso_data), .w_ready_o(out_w_ready),
    .r_v_o(wh_v_o), .r_data_o(wh_data_o), .r_ready_i(out_deq)
  );

  // Wormhole clock back to manycore clock
  wh_async_fifo #(.lg_fifo_depth_p(lg_fifo_depth_p)) wh_to_mc_inst (
    .w_clk_i(clk_i), .r_clk_i(manycore_clk_i), .arst_n_i(arst_n_i),
    .w_v_i(in_enq), .w_data_i(wh_data_i), .w_ready_o(wh_ready_o),
    .r_v_o(in_r_v), .r_data_o(in_r_data), .r_ready_i(in_deq)
  );

  wh_sipo sipo_inst (
    .clk_i(manycore_clk_i), .arst_n_i(arst_n_i),
    .v_i(in_r_v), .data_i(in_r_data), .ready_o(sipo_ready),
    .v_o(rx_v_o), .data_o(rx_data_o), .ready_i(rx_ready_i)
  );

endmodule

`default_nettype wire

//--- verilog/mc_link_deframer.sv
`default_nettype none
`timescale 1ns/1ns

module mc_link_deframer (
  input  wire                                                   manycore_clk_i,
  input  wire                                                   arst_n_i,
  input  wire  [mc_wh_pkg::wh_coord_width-1:0]                  local_x_i,
  input  wire  [mc_wh_pkg::wh_coord_width-1:0]                  local_y_i,
  input  wire  [mc_wh_pkg::num_nets-1:0]                        rx_v_i,
  input  wire  [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::wh_packet_bits-1:0] rx_data_i,
  output logic [mc_wh_pkg::num_nets-1:0]                        rx_ready_o,
  output logic [mc_wh_pkg::num_nets-1:0]                        mc_v_o,
  output logic [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::mc_packet_width-1:0] mc_data_o,
  input  wire  [mc_wh_pkg::num_nets-1:0]                        mc_ready_i,
  output logic [mc_wh_pkg::num_nets-1:0]                        drop_o
);

  localparam int pkt_bits_lp = $bits(mc_wh_pkg::wh_packet_t);

  mc_wh_pkg::wh_packet_t [mc_wh_pkg::num_nets-1:0] rx_pkt;
  logic                  [mc_wh_pkg::num_nets-1:0] hdr_ok;
  logic                  [mc_wh_pkg::num_nets-1:0] code_ok;
  logic                  [mc_wh_pkg::num_nets-1:0] pkt_good;

  always_comb
  begin
    for (int i = 0; i < mc_wh_pkg::num_nets; i++)
    begin
      rx_pkt[i] = rx_data_i[i][pkt_bits_lp-1:0];
      hdr_ok[i] = (rx_pkt[i].hdr.x == local_x_i) && (rx_pkt[i].hdr.y == local_y_i)
               && (rx_pkt[i].hdr.len == 2'(mc_wh_pkg::wh_ratio - 1));
      // Forward net carries requests, reverse net carries returns
      if (i == mc_wh_pkg::fwd_net)
        code_ok[i] = (rx_pkt[i].payload.fwd.op != mc_wh_pkg::mc_reserved_code);
      else
        code_ok[i] = (rx_pkt[i].payload.rev.pkt_type != mc_wh_pkg::mc_reserved_code);
      pkt_good[i]  = hdr_ok[i] & code_ok[i];
      mc_data_o[i] = rx_pkt[i].payload;
    end
  end

  assign mc_v_o = rx_v_i & pkt_good;

  // Bad packets are always accepted so they drain out of the lane
  assign rx_ready_o = ~pkt_good | mc_ready_i;

  // Sticky until the next reset
  always_ff @(posedge manycore_clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
      drop_o <= '0;
    else
      drop_o <= drop_o | (rx_v_i & ~pkt_good);
  end

endmodule

`default_nettype wire

//--- verilog/mc_wh_adapter.sv
`default_nettype none
`timescale 1ns/1ns

module mc_wh_adapter #(
  parameter int lg_fifo_depth_p = 3
) (
  input  wire                                                   manycore_clk_i,
  input  wire                                                   clk_i,
  input  wire                                                   arst_n_i,
  input  wire  [mc_wh_pkg::num_nets-1:0]                        mc_v_i,
  input  wire  [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::mc_packet_width-1:0] mc_data_i,
  output logic [mc_wh_pkg::num_nets-1:0]                        mc_ready_o,
  output logic [mc_wh_pkg::num_nets-1:0]                        mc_v_o,
  output logic [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::mc_packet_width-1:0] mc_data_o,
  input  wire  [mc_wh_pkg::num_nets-1:0]                        mc_ready_i,
  input  wire  [mc_wh_pkg::num_nets-1:0]                        wh_v_i,
  input  wire  [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::wh_flit_width-1:0] wh_data_i,
  output logic [mc_wh_pkg::num_nets-1:0]                        wh_ready_o,
  output logic [mc_wh_pkg::num_nets-1:0]                        wh_v_o,
  output logic [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::wh_flit_width-1:0] wh_data_o,
  input  wire  [mc_wh_pkg::num_nets-1:0]                        wh_ready_i,
  input  wire  [mc_wh_pkg::wh_coord_width-1:0]                  dest_x_i,
  input  wire  [mc_wh_pkg::wh_coord_width-1:0]                  dest_y_i,
  input  wire  [mc_wh_pkg::wh_coord_width-1:0]                  local_x_i,
  input  wire  [mc_wh_pkg::wh_coord_width-1:0]                  local_y_i,
  output logic [mc_wh_pkg::num_nets-1:0]                        drop_o
);

  logic [mc_wh_pkg::num_nets-1:0]                               pkt_v, pkt_ready;
  logic [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::wh_packet_bits-1:0] pkt_data;
  logic [mc_wh_pkg::num_nets-1:0]                               rx_v, rx_ready;
  logic [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::wh_packet_bits-1:0] rx_data;

  mc_link_framer framer_inst (
    .manycore_clk_i(manycore_clk_i), .arst_n_i(arst_n_i),
    .mc_v_i(mc_v_i), .mc_data_i(mc_data_i), .mc_ready_o(mc_ready_o),
    .dest_x_i(dest_x_i), .dest_y_i(dest_y_i),
    .pkt_v_o(pkt_v), .pkt_data_o(pkt_data), .pkt_ready_i(pkt_ready)
  );

  // Net 0 reverse, net 1 forward
  for (genvar i = 0; i < mc_wh_pkg::num_nets; i++)
  begin : g_lane
    wh_net_lane #(.lg_fifo_depth_p(lg_fifo_depth_p)) lane_inst (
      .manycore_clk_i(manycore_clk_i), .clk_i(clk_i), .arst_n_i(arst_n_i),
      .tx_v_i(pkt_v[i]), .tx_data_i(pkt_data[i]), .tx_ready_o(pkt_ready[i]),
      .rx_v_o(rx_v[i]), .rx_data_o(rx_data[i]), .rx_ready_i(rx_ready[i]),
      .wh_v_o(wh_v_o[i]), .wh_data_o(wh_data_o[i]), .wh_ready_i(wh_ready_i[i]),
      .wh_v_i(wh_v_i[i]), .wh_data_i(wh_data_i[i]), .wh_ready_o(wh_ready_o[i])
    );
  end

  mc_link_deframer deframer_inst (
    .manycore_clk_i(manycore_clk_i), .arst_n_i(arst_n_i),
    .local_x_i(local_x_i), .local_y_i(local_y_i),
    .rx_v_i(rx_v), .rx_data_i(rx_data), .rx_ready_o(rx_ready),
    .mc_v_o(mc_v_o), .mc_data_o(mc_data_o), .mc_ready_i(mc_ready_i),
    .drop_o(drop_o)
  );

endmodule

`default_nettype wire

//--- dv/mc_wh_adapter_asserts.sv
`default_nettype none
`timescale 1ns/1ns

module mc_wh_adapter_asserts (
  input wire                                                      manycore_clk_i,
  input wire                                                      clk_i,
  input wire                                                      arst_n_i,
  input wire [mc_wh_pkg::num_nets-1:0]                            mc_v_o,
  input wire [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::mc_packet_width-1:0] mc_data_o,
  input wire [mc_wh_pkg::num_nets-1:0]                            mc_ready_i,
  input wire [mc_wh_pkg::num_nets-1:0]                            wh_v_o,
  input wire [mc_wh_pkg::num_nets-1:0][mc_wh_pkg::wh_flit_width-1:0] wh_data_o,
  input wire [mc_wh_pkg::num_nets-1:0]                            wh_ready_i,
  input wire [mc_wh_pkg::num_nets-1:0]                            drop_o
);

  for (genvar i = 0; i < mc_wh_pkg::num_nets; i++)
  begin : g_net
    // A stalled output holds valid and data
    mc_hold_a: assert property (@(posedge manycore_clk_i) disable iff (!arst_n_i)
      (mc_v_o[i] && !mc_ready_i[i]) |=> (mc_v_o[i] && $stable(mc_data_o[i])))
      else $error("mc_v_o dropped or mc_data_o changed while stalled");

    wh_hold_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (wh_v_o[i] && !wh_ready_i[i]) |=> (wh_v_o[i] && $stable(wh_data_o[i])))
      else $error("wh_v_o dropped or wh_data_o changed while stalled");
  end

  mc_quiet_a: assert property (@(posedge manycore_clk_i)
    !arst_n_i |-> (mc_v_o == '0 && drop_o == '0))
    else $error("mc_v_o or drop_o high during reset");

  wh_quiet_a: assert property (@(posedge clk_i)
    !arst_n_i |-> (wh_v_o == '0))
    else $error("wh_v_o high during reset");

  // Drop flags are sticky
  drop_sticky_a: assert property (@(posedge manycore_clk_i) disable iff (!arst_n_i)
    (($past(drop_o) & ~drop_o) == '0))
    else $error("drop_o fell outside reset");

endmodule

bind mc_wh_adapter mc_wh_adapter_asserts asserts_inst (
  .manycore_clk_i(manycore_clk_i), .clk_i(clk_i), .arst_n_i(arst_n_i),
  .mc_v_o(mc_v_o), .mc_data_o(mc_data_o), .mc_ready_i(mc_ready_i),
  .wh_v_o(wh_v_o), .wh_data_o(wh_data_o), .wh_ready_i(wh_ready_i),
  .drop_o(drop_o)
);

`default_nettype wire

//--- dv/tb_mc_wh_adapter.sv
`default_nettype none
`timescale 1ns/1ns

module tb_mc_wh_adapter;

  logic              manycore_clk_i;
  logic              clk_i;
  logic              arst_n_i;
  logic [1:0]        mc_v_i;
  logic [1:0][63:0]  mc_data_i;
  wire  [1:0]        mc_ready_o;
  wire  [1:0]        mc_v_o;
  wire  [1:0][63:0]  mc_data_o;
  logic [1:0]        mc_ready_i;
  wire  [1:0]        wh_v_i;
  wire  [1:0][31:0]  wh_data_i;
  wire  [1:0]        wh_ready_o;
  wire  [1:0]        wh_v_o;
  wire  [1:0][31:0]  wh_data_o;
  wire  [1:0]        wh_ready_i;
  logic [3:0]        dest_x_i;
  logic [3:0]        dest_y_i;
  logic [3:0]        local_x_i;
  logic [3:0]        local_y_i;
  wire  [1:0]        drop_o;

  logic [31:0] lfsr_state;
  logic        stall_en;
  logic [1:0]  wh_gate;
  logic [63:0] exp_rev_q[$];
  logic [63:0] exp_fwd_q[$];

  // Wormhole loopback, a flit moves only when both sides agree
  assign wh_ready_i = wh_ready_o & wh_gate;
  assign wh_v_i     = wh_v_o & wh_gate;
  assign wh_data_i  = wh_data_o;

  mc_wh_adapter #(.lg_fifo_depth_p(3)) mc_wh_adapter_inst (
    .manycore_clk_i(manycore_clk_i), .clk_i(clk_i), .arst_n_i(arst_n_i),
    .mc_v_i(mc_v_i), .mc_data_i(mc_data_i), .mc_ready_o(mc_ready_o),
    .mc_v_o(mc_v_o), .mc_data_o(mc_data_o), .mc_ready_i(mc_ready_i),
    .wh_v_i(wh_v_i), .wh_data_i(wh_data_i), .wh_ready_o(wh_ready_o),
    .wh_v_o(wh_v_o), .wh_data_o(wh_data_o), .wh_ready_i(wh_ready_i),
    .dest_x_i(dest_x_i), .dest_y_i(dest_y_i),
    .local_x_i(local_x_i), .local_y_i(local_y_i), .drop_o(drop_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial
  begin
    manycore_clk_i = 1'b0;
    forever #7 manycore_clk_i = ~manycore_clk_i;
  end

  task automatic fail_now(input string what);
    $display("[ERROR] %s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
    $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_next(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [63:0] random_word();
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < 64; i++)
      w[i] = take_bit();
    return w;
  endfunction

  // Op sits in bits 63:62, pkt_type in bits 44:43
  function automatic bit expect_delivery(input int net, input logic [63:0] p);
    logic [1:0] code;
    code = (net == 1) ? p[63:62] : p[44:43];
    return (dest_x_i == local_x_i) && (dest_y_i == local_y_i) && (code != 2'd3);
  endfunction

  // Stall sources on each clock
  initial
  begin
    mc_ready_i = 2'b11;
    forever
    begin
      @(posedge manycore_clk_i);
      #1;
      for (int n = 0; n < 2; n++)
        mc_ready_i[n] = stall_en ? take_bit() : 1'b1;
    end
  end

  initial
  begin
    wh_gate = 2'b11;
    forever
    begin
      @(posedge clk_i);
      #1;
      for (int n = 0; n < 2; n++)
        wh_gate[n] = stall_en ? take_bit() : 1'b1;
    end
  end

  // Scoreboard
  always @(posedge manycore_clk_i)
  begin
    for (int n = 0; n < 2; n++)
    begin
      if (arst_n_i && mc_v_o[n] && mc_ready_i[n])
      begin
        if ((n == 1 && exp_fwd_q.size() == 0) || (n == 0 && exp_rev_q.size() == 0))
          fail_now($sformatf("Net %0d delivered a packet that should not arrive", n));
        else if (n == 1)
        begin
          assert (mc_data_o[1] == exp_fwd_q[0])
            else report_mismatch("mc_data_o[1]", mc_data_o[1], exp_fwd_q[0]);
          void'(exp_fwd_q.pop_front());
        end
        else
        begin
          assert (mc_data_o[0] == exp_rev_q[0])
            else report_mismatch("mc_data_o[0]", mc_data_o[0], exp_rev_q[0]);
          void'(exp_rev_q.pop_front());
        end
      end
    end
  end

  // Called 1 ns after a manycore edge
  task automatic send_packet(input int net, input logic [63:0] pkt);
    int waited;
    waited = 0;
    mc_v_i[net]    = 1'b1;
    mc_data_i[net] = pkt;
    do
    begin
      @(posedge manycore_clk_i);
      waited++;
      if (waited > 400)
        fail_now($sformatf("Net %0d never accepted a packet", net));
    end
    while (!mc_ready_o[net]);
    if (expect_delivery(net, pkt))
    begin
      if (net == 1)
        exp_fwd_q.push_back(pkt);
      else
        exp_rev_q.push_back(pkt);
    end
    #1;
    mc_v_i[net] = 1'b0;
  endtask

  task automatic run_traffic(input int net, input int count);
    logic [63:0] p;
    for (int k = 0; k < count; k++)
    begin
      p = random_word();
      if (p[63:62] == 2'd3)
        p[63] = 1'b0;
      if (p[44:43] == 2'd3)
        p[44] = 1'b0;
      send_packet(net, p);
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_fwd_q.size() != 0 || exp_rev_q.size() != 0)
    begin
      @(posedge manycore_clk_i);
      waited++;
      if (waited > 5000)
        fail_now("Expected packets never came back");
    end
  endtask

  task automatic wait_drop(input int net);
    int waited;
    waited = 0;
    while (!drop_o[net])
    begin
      @(posedge manycore_clk_i);
      waited++;
      if (waited > 1000)
        fail_now($sformatf("drop_o[%0d] was never set", net));
    end
  endtask

  task automatic apply_reset();
    @(posedge manycore_clk_i);
    #1;
    arst_n_i = 1'b0;
    repeat (2) @(posedge manycore_clk_i);
    #1;
    arst_n_i = 1'b1;
  endtask

  task automatic check_idle();
    assert (mc_v_o == 2'b00) else report_mismatch("mc_v_o", 64'(mc_v_o), 64'h0);
    assert (wh_v_o == 2'b00) else report_mismatch("wh_v_o", 64'(wh_v_o), 64'h0);
    assert (drop_o == 2'b00) else report_mismatch("drop_o", 64'(drop_o), 64'h0);
  endtask

  initial
  begin
    logic [63:0] p;
    lfsr_state = 32'hef6c_0e08;
    stall_en   = 1'b0;
    arst_n_i   = 1'b0;
    mc_v_i     = 2'b00;
    mc_data_i  = '0;
    local_x_i  = 4'd2;
    local_y_i  = 4'd1;
    dest_x_i   = 4'd2;
    dest_y_i   = 4'd1;
    repeat (2) @(posedge manycore_clk_i);
    #1;
    arst_n_i = 1'b1;
    @(posedge manycore_clk_i);
    #1;
    check_idle();

    // Loopback on both nets without stalls
    fork
      run_traffic(0, 12);
      run_traffic(1, 12);
    join
    wait_drained();

    // Random stalls on both sides
    stall_en = 1'b1;
    @(posedge manycore_clk_i);
    #1;
    fork
      run_traffic(0, 24);
      run_traffic(1, 24);
    join
    wait_drained();
    stall_en = 1'b0;
    @(posedge manycore_clk_i);
    #1;

    // Packets addressed elsewhere
    dest_x_i = 4'd5;
    fork
      run_traffic(0, 4);
      run_traffic(1, 4);
    join
    wait_drop(0);
    wait_drop(1);

    // Right column but wrong row
    @(posedge manycore_clk_i);
    #1;
    dest_x_i = 4'd2;
    dest_y_i = 4'd6;
    fork
      run_traffic(0, 4);
      run_traffic(1, 4);
    join
    repeat (60) @(posedge manycore_clk_i);

    // Reset again clears the sticky flags
    apply_reset();
    dest_y_i = 4'd1;
    @(posedge manycore_clk_i);
    #1;
    check_idle();

    // Same bits, reserved op but a legal pkt_type
    p = random_word();
    p[63:62] = 2'd3;
    p[44:43] = 2'd1;
    send_packet(1, p);
    send_packet(0, p);
    wait_drop(1);
    wait_drained();
    repeat (40) @(posedge manycore_clk_i);
    assert (drop_o == 2'b10) else report_mismatch("drop_o", 64'(drop_o), 64'h2);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
verilog/mc_wh_pkg.sv
verilog/mc_link_framer.sv
verilog/wh_piso.sv
verilog/wh_sipo.sv
verilog/wh_async_fifo.sv
verilog/wh_net_lane.sv
verilog/mc_link_deframer.sv
verilog/mc_wh_adapter.sv
dv/mc_wh_adapter_asserts.sv
dv/tb_mc_wh_adapter.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mc_wh_adapter
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = RESULT: FAIL
PASS_MSG  = RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
